// File: build.f
+incdir+logic
logic/fetch_pkg.sv
logic/fetch_request.sv
logic/fetch_queue.sv
logic/instr_issue.sv
logic/frontend_top.sv
sim/tb_clock.sv
sim/l15_model.sv
sim/frontend_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module frontend_tb -f build.f -o frontend_sim \
	&& ./obj_dir/frontend_sim > sim.log 2>&1 \
	|| echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
exit 0

// File: sim/frontend_tb.sv
`include "fetch_defines.svh"

module frontend_tb;
	import fetch_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int MAX_ACK_DLY = 3;
	localparam int MAX_RESP_DLY = 6;
	localparam int NUM_ROUNDS = 8;
	localparam int RUN_MAX = 24;
	localparam int IDLE_CYCLES = 30;
	// worst fetch round trip, times four for slow decode
	localparam int INSTR_CYCLES = 4 * (MAX_ACK_DLY + MAX_RESP_DLY + 6);
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 100 +
		(NUM_ROUNDS + 2) * (RUN_MAX * INSTR_CYCLES + 2 * IDLE_CYCLES);

	logic clk;
	logic nrst;
	logic redirect_valid;
	logic [31:0] redirect_pc;
	logic exception_pending;
	logic [31:0] epc;
	logic req_val;
	l15_req_t l15_req;
	logic req_ack;
	logic resp_val;
	l15_resp_t l15_resp;
	logic resp_ack;
	logic issue_valid;
	issue_t issue;
	logic issue_ready;

	logic [31:0] exp_pc; // reference model pc
	issue_t exp_issue;
	logic stalled; // misaligned entry issued, nothing may follow
	logic wake_seen;
	int issued = 0;
	int loads_seen = 0;

	tb_clock #(.PERIOD(8)) i_tb_clock (.clk(clk));

	l15_model #(
		.MAX_ACK_DLY(MAX_ACK_DLY),
		.MAX_RESP_DLY(MAX_RESP_DLY)
	) i_l15_model (
		.clk(clk),
		.nrst(nrst),
		.req_val(req_val),
		.l15_req(l15_req),
		.req_ack(req_ack),
		.resp_val(resp_val),
		.l15_resp(l15_resp)
	);

	frontend_top i_frontend_top (
		.clk(clk),
		.nrst(nrst),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.exception_pending(exception_pending),
		.epc(epc),
		.req_val(req_val),
		.l15_req(l15_req),
		.req_ack(req_ack),
		.resp_val(resp_val),
		.l15_resp(l15_resp),
		.resp_ack(resp_ack),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_ready(issue_ready)
	);

	// same content as the cache model, in cache byte order
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] a;
		a = {addr[31:2], 2'b00};
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
	endfunction

	function automatic issue_t expected_issue(input logic [31:0] pc);
		issue_t e;
		logic [31:0] w;
		w = mem_word(pc);
		e.pc = pc;
		e.misaligned = pc[1:0] != 2'b00;
		e.instr = e.misaligned ? `FETCH_NOP : {w[7:0], w[15:8], w[23:16], w[31:24]};
		e.illegal = e.instr[1:0] != 2'b11; // 32-bit encodings only
		return e;
	endfunction

	function automatic logic [31:0] random_target();
		return 32'h4000_0000 + (($urandom % 32'd4096) << 2);
	endfunction

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp)
		else
		begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic run_instrs(input int count, input int ready_pct);
		int target;
		target = issued + count;
		while (issued < target)
		begin
			@(posedge clk);
			issue_ready <= ($urandom % 100) < ready_pct;
		end
	endtask

	// decode is held off in the redirect cycle
	task automatic change_stream(input logic take_redirect, input logic take_exception,
		input logic [31:0] target_r, input logic [31:0] target_e);
		@(posedge clk);
		redirect_valid <= take_redirect;
		redirect_pc <= target_r;
		exception_pending <= take_exception;
		epc <= target_e;
		issue_ready <= 1'b0;
		@(posedge clk);
		redirect_valid <= 1'b0;
		exception_pending <= 1'b0;
	endtask

	task automatic misaligned_round();
		int base;
		change_stream(1'b1, 1'b0, random_target() | (32'd1 + $urandom % 32'd3), '0);
		base = issued;
		while (issued == base)
		begin
			@(posedge clk);
			issue_ready <= 1'b1;
		end
		repeat (IDLE_CYCLES)
			@(posedge clk); // decode ready, yet nothing more may come
		check_value("issued count", issued, base + 1);
		change_stream(1'b1, 1'b0, random_target(), '0);
	endtask

	always @(posedge clk)
	begin
		if (!nrst)
		begin
			exp_pc = `FETCH_RESET_PC;
			stalled = 1'b0;
			wake_seen = 1'b0;
			check_value("req_val", 32'(req_val), 32'd0);
			check_value("resp_ack", 32'(resp_ack), 32'd0);
			check_value("issue_valid", 32'(issue_valid), 32'd0);
		end
		else
		begin
			if (req_val)
			begin
				assert (wake_seen)
				else
				begin
					$display("request raised at %0t before the wake-up response", $time);
					abort_run();
				end
				check_value("l15_req.address[1:0]", 32'(l15_req.address[1:0]), 32'd0);
				check_value("l15_req.rqtype", 32'(l15_req.rqtype), 32'(`RQ_IFILL));
				check_value("l15_req.size", 32'(l15_req.size), 32'(`RQ_SIZE_LINE));
			end
			if (resp_val)
				check_value("resp_ack", 32'(resp_ack), 32'd1);
			if (issue_valid && issue_ready)
			begin
				assert (!stalled)
				else
				begin
					$display("instruction issued at %0t after a misaligned entry", $time);
					abort_run();
				end
				exp_issue = expected_issue(exp_pc);
				check_value("issue.pc", issue.pc, exp_issue.pc);
				check_value("issue.instr", issue.instr, exp_issue.instr);
				check_value("issue.illegal", 32'(issue.illegal), 32'(exp_issue.illegal));
				check_value("issue.misaligned", 32'(issue.misaligned),
					32'(exp_issue.misaligned));
				if (exp_issue.misaligned)
					stalled = 1'b1;
				else
					exp_pc = exp_pc + 32'd4;
				issued <= issued + 1;
			end
			if (exception_pending || redirect_valid)
			begin
				exp_pc = exception_pending ? epc : redirect_pc; // exception wins
				stalled = 1'b0;
			end
			if (resp_val && l15_resp.returntype == `RET_INT)
				wake_seen = 1'b1;
			if (resp_val && l15_resp.returntype == `RET_LOAD)
				loads_seen <= loads_seen + 1;
		end
	end

	initial
	begin
		void'($urandom(32'hfae8));
		nrst <= 1'b0;
		redirect_valid <= 1'b0;
		redirect_pc <= '0;
		exception_pending <= 1'b0;
		epc <= '0;
		issue_ready <= 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		nrst <= 1'b1;
		run_instrs(RUN_MAX, 75);
		repeat (IDLE_CYCLES)
		begin
			@(posedge clk);
			issue_ready <= 1'b0; // queue fills, requests must stop
		end
		run_instrs(RUN_MAX, 25);
		for (int r = 0; r < NUM_ROUNDS; r++)
		begin
			case (r % 4)
				0: change_stream(1'b1, 1'b0, random_target(), '0);
				1: change_stream(1'b1, 1'b1, random_target(), random_target());
				2: change_stream(1'b0, 1'b1, '0, random_target());
				default: misaligned_round();
			endcase
			run_instrs(1 + int'($urandom % RUN_MAX), 40 + int'($urandom % 60));
		end
		repeat (4)
			@(posedge clk);
		if (loads_seen > 0)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
		begin
			$display("no stray load reached the front end, %0d issued", issued);
			abort_run();
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES)
			@(posedge clk);
		$display("watchdog expired after %0d cycles, the front end stopped issuing",
			WATCHDOG_CYCLES);
		abort_run();
	end

endmodule

// File: sim/l15_model.sv
`include "fetch_defines.svh"

module l15_model #(
	parameter int MAX_ACK_DLY = 3,
	parameter int MAX_RESP_DLY = 6,
	parameter int LOAD_ODDS = 8 // one stray load per this many idle cycles
) (
	input logic clk,
	input logic nrst,
	input logic req_val,
	input fetch_pkg::l15_req_t l15_req,
	output logic req_ack,
	output logic resp_val,
	output fetch_pkg::l15_resp_t l15_resp
);
	import fetch_pkg::*;

	logic woken;
	logic pending; // fill accepted, response not yet sent
	logic [31:0] fill_addr;
	int wake_dly;
	int ack_dly;
	int resp_dly;

	// memory content in cache byte order, a function of the whole address
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] a;
		a = {addr[31:2], 2'b00};
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
	endfunction

	function automatic l15_resp_t make_resp(input logic [3:0] rtype, input logic [63:0] d0,
		input logic [63:0] d1);
		l15_resp_t r;
		r.returntype = rtype;
		r.data_0 = d0;
		r.data_1 = d1;
		return r;
	endfunction

	always @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			req_ack <= 1'b0;
			resp_val <= 1'b0;
			l15_resp <= '0;
			woken = 1'b0;
			pending = 1'b0;
			fill_addr = '0;
			wake_dly = 2 + int'($urandom % 8);
			ack_dly = 0;
			resp_dly = 0;
		end
		else
		begin
			req_ack <= 1'b0;
			resp_val <= 1'b0;
			if (req_val && req_ack)
			begin
				pending = 1'b1; // accepted in this cycle
				fill_addr = l15_req.address;
				resp_dly = int'($urandom % (MAX_RESP_DLY + 1));
			end
			else if (req_val && !pending)
			begin
				if (ack_dly == 0)
				begin
					req_ack <= 1'b1;
					ack_dly = int'($urandom % (MAX_ACK_DLY + 1));
				end
				else
					ack_dly = ack_dly - 1;
			end
			if (!woken)
			begin
				if (wake_dly == 0)
				begin
					resp_val <= 1'b1;
					l15_resp <= make_resp(`RET_INT, '0, '0);
					woken = 1'b1;
				end
				else
					wake_dly = wake_dly - 1;
			end
			else if (pending && resp_dly == 0)
			begin
				resp_val <= 1'b1;
				l15_resp <= make_resp(`RET_IFILL,
					{mem_word({fill_addr[31:4], 4'h0}), mem_word({fill_addr[31:4], 4'h4})},
					{mem_word({fill_addr[31:4], 4'h8}), mem_word({fill_addr[31:4], 4'hc})});
				pending = 1'b0;
			end
			else
			begin
				if (pending)
					resp_dly = resp_dly - 1;
				if ($urandom % LOAD_ODDS == 0)
				begin
					resp_val <= 1'b1; // unrelated traffic on the response bus
					l15_resp <= make_resp(`RET_LOAD, {$urandom, $urandom}, {$urandom, $urandom});
				end
			end
		end
	end

endmodule

// File: sim/tb_clock.sv
module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk; // even period only
	end

endmodule

// File: logic/frontend_top.sv
module frontend_top (
	input logic clk,
	input logic nrst,
	input logic redirect_valid,
	input logic [31:0] redirect_pc,
	input logic exception_pending,
	input logic [31:0] epc,
	output logic req_val,
	output fetch_pkg::l15_req_t l15_req,
	input logic req_ack,
	input logic resp_val,
	input fetch_pkg::l15_resp_t l15_resp,
	output logic resp_ack,
	output logic issue_valid,
	output fetch_pkg::issue_t issue,
	input logic issue_ready
);
	import fetch_pkg::*;

	fetch_entry_t push_entry;
	fetch_entry_t head_entry;
	logic push;
	logic pop;
	logic full;
	logic empty;
	logic flush;

	assign flush = redirect_valid | exception_pending; // any change of stream

	fetch_request i_fetch_request (
		.clk(clk),
		.nrst(nrst),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.exception_pending(exception_pending),
		.epc(epc),
		.req_val(req_val),
		.l15_req(l15_req),
		.req_ack(req_ack),
		.resp_val(resp_val),
		.l15_resp(l15_resp),
		.resp_ack(resp_ack),
		.full(full),
		.push(push),
		.entry(push_entry)
	);

	fetch_queue #(
		.entry_t(fetch_entry_t)
	) i_fetch_queue (
		.clk(clk),
		.nrst(nrst),
		.flush(flush),
		.push(push),
		.din(push_entry),
		.pop(pop),
		.dout(head_entry),
		.full(full),
		.empty(empty)
	);

	instr_issue i_instr_issue (
		.clk(clk),
		.nrst(nrst),
		.flush(flush),
		.empty(empty),
		.entry(head_entry),
		.pop(pop),
		.issue_ready(issue_ready),
		.issue_valid(issue_valid),
		.issue(issue)
	);

endmodule

// File: logic/instr_issue.sv
`include "fetch_defines.svh"

module instr_issue (
	input logic clk,
	input logic nrst,
	input logic flush,
	input logic empty,
	input fetch_pkg::fetch_entry_t entry,
	output logic pop,
	input logic issue_ready,
	output logic issue_valid,
	output fetch_pkg::issue_t issue
);
	import fetch_pkg::*;

	issue_t issue_d;
	logic [31:0] swapped;

	// cache delivers big endian words
	assign swapped = {entry.raw[7:0], entry.raw[15:8], entry.raw[23:16], entry.raw[31:24]};

	always_comb
	begin
		issue_d.pc = entry.pc;
		issue_d.misaligned = entry.misaligned;
		issue_d.instr = entry.misaligned ? `FETCH_NOP : swapped;
		// only 32-bit encodings, no compressed set
		issue_d.illegal = issue_d.instr[1:0] != 2'b11;
	end

	// output register free or draining this cycle
	assign pop = !empty && !flush && (!issue_valid || issue_ready);

	always_ff @(posedge clk)
	begin
		if (pop)
			issue <= issue_d;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			issue_valid <= 1'b0;
		else if (flush)
			issue_valid <= 1'b0; // drop whatever decode has not taken
		else if (pop)
			issue_valid <= 1'b1;
		else if (issue_ready)
			issue_valid <= 1'b0;
	end

	a_issue_hold: assert property (@(posedge clk) disable iff (!nrst)
		issue_valid && !issue_ready && !flush |=> issue_valid && $stable(issue));

endmodule

// File: logic/fetch_queue.sv
`include "fetch_defines.svh"

module fetch_queue #(
	parameter type entry_t = logic [31:0],
	parameter int DEPTH = `FETCH_QUEUE_DEPTH
) (
	input logic clk,
	input logic nrst,
	input logic flush,
	input logic push,
	input entry_t din,
	input logic pop,
	output entry_t dout,
	output logic full,
	output logic empty
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	entry_t mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0] count;
	logic do_push;
	logic do_pop;

	// wraps for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full = count == (PTR_W + 1)'(DEPTH);
	assign empty = count == '0;
	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign dout = mem[rd_ptr]; // head is visible the cycle after its push

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!nrst) !(push && full));
	a_no_underflow: assert property (@(posedge clk) disable iff (!nrst) !(pop && empty));

endmodule

// File: logic/fetch_request.sv
`include "fetch_defines.svh"

module fetch_request (
	input logic clk,
	input logic nrst,
	input logic redirect_valid,
	input logic [31:0] redirect_pc,
	input logic exception_pending,
	input logic [31:0] epc,
	output logic req_val,
	output fetch_pkg::l15_req_t l15_req,
	input logic req_ack,
	input logic resp_val,
	input fetch_pkg::l15_resp_t l15_resp,
	output logic resp_ack,
	input logic full,
	output logic push,
	output fetch_pkg::fetch_entry_t entry
);
	typedef enum logic [1:0] {
		S_REQ,
		S_WAIT_ACK,
		S_RESP
	} state_t;

	state_t state_q;
	state_t state_d;
	logic [31:0] pc_q;
	logic [31:0] req_addr_q; // address of the outstanding fill
	logic awake_q;
	logic discard_q;
	logic mis_sent_q;

	logic redir;
	logic [31:0] redir_pc;
	logic pc_mis;
	logic fill_done;
	logic push_fill;
	logic push_mis;
	logic [31:0] word;

	assign redir = exception_pending | redirect_valid;
	assign redir_pc = exception_pending ? epc : redirect_pc; // exception has priority
	assign pc_mis = pc_q[1:0] != 2'b00;

	assign fill_done = (state_q == S_RESP) && resp_val && (l15_resp.returntype == `RET_IFILL);
	assign push_fill = fill_done && !discard_q && !redir;
	// misaligned target goes straight to the queue, never to the cache
	assign push_mis = awake_q && pc_mis && !mis_sent_q && !full && !redir;
	assign push = push_fill | push_mis;

	// every response is taken, including stray loads
	assign resp_ack = resp_val;

	// once raised, req_val stays up in S_WAIT_ACK until the ack
	assign req_val = (state_q == S_WAIT_ACK) ||
		((state_q == S_REQ) && awake_q && !full && !pc_mis && !redir);

	assign l15_req.rqtype = `RQ_IFILL;
	assign l15_req.size = `RQ_SIZE_LINE;
	assign l15_req.address = (state_q == S_REQ) ? pc_q : req_addr_q;

	always_comb
	begin
		case (req_addr_q[3:2])
			2'b00: word = l15_resp.data_0[63:32];
			2'b01: word = l15_resp.data_0[31:0];
			2'b10: word = l15_resp.data_1[63:32];
			default: word = l15_resp.data_1[31:0];
		endcase
	end

	assign entry.pc = pc_q; // equals req_addr_q for any fill that is pushed
	assign entry.raw = word;
	assign entry.misaligned = pc_mis;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			S_REQ:
				if (req_val)
					state_d = req_ack ? S_RESP : S_WAIT_ACK;
			S_WAIT_ACK:
				if (req_ack)
					state_d = S_RESP;
			S_RESP:
				if (fill_done)
					state_d = S_REQ;
			default:
				state_d = S_REQ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (state_q == S_REQ && req_val)
			req_addr_q <= pc_q;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state_q <= S_REQ;
			pc_q <= `FETCH_RESET_PC;
			awake_q <= 1'b0;
			discard_q <= 1'b0;
			mis_sent_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			if (resp_val && l15_resp.returntype == `RET_INT)
				awake_q <= 1'b1;
			if (redir)
				pc_q <= redir_pc;
			else if (push_fill)
				pc_q <= pc_q + 32'd4;
			// a fill in flight across a redirect belongs to the old stream
			if (fill_done)
				discard_q <= 1'b0;
			else if (redir && state_q != S_REQ)
				discard_q <= 1'b1;
			if (redir)
				mis_sent_q <= 1'b0;
			else if (push_mis)
				mis_sent_q <= 1'b1;
		end
	end

	a_req_stable: assert property (@(posedge clk) disable iff (!nrst)
		req_val && !req_ack |=> req_val && $stable(l15_req));

	// only one fill in flight, so the queue cannot have filled up meanwhile
	a_push_not_full: assert property (@(posedge clk) disable iff (!nrst)
		push |-> !full);

endmodule

// File: logic/fetch_pkg.sv
package fetch_pkg;

	// request header towards the l1.5
	typedef struct packed {
		logic [4:0] rqtype;
		logic [2:0] size;
		logic [31:0] address;
	} l15_req_t;

	// one 128-bit response
	typedef struct packed {
		logic [3:0] returntype;
		logic [63:0] data_0;
		logic [63:0] data_1;
	} l15_resp_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] raw; // still in cache byte order
		logic misaligned;
	} fetch_entry_t;

	// handed to decode
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		logic illegal;
		logic misaligned;
	} issue_t;

endpackage

// File: logic/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// pc after reset
`define FETCH_RESET_PC 32'h4000_0000

// add x0, x0, x0
`define FETCH_NOP 32'h0000_0033

// l1.5 return types
`define RET_LOAD 4'b0000
`define RET_IFILL 4'b0001
`define RET_INT 4'b0111 // wake-up interrupt

// request encoding towards the l1.5
`define RQ_IFILL 5'b10000
`define RQ_SIZE_LINE 3'b100 // 16-byte line

// fetch queue entries
`define FETCH_QUEUE_DEPTH 4

`endif
